//--- exec_top.f
verilog/mips_isa_pkg.sv
verilog/exec_pipe_pkg.sv
verilog/sgl_alu.sv
verilog/mul_div_iter.sv
verilog/op_issue.sv
verilog/op_queue.sv
verilog/exec_unit.sv
verilog/exec_top.sv
testbench/exec_top_asserts.sv
testbench/exec_top_tb.sv

//--- run.sh
#!/bin/sh
# Builds the exec_top testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f exec_top.f \
   --top-module exec_top_tb -o exec_top_sim

# The error limit lets the testbench see a fired assertion and end the run itself.
out=$(./obj_dir/exec_top_sim +verilator+error+limit+100 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Test passed"

//--- testbench/exec_top_tb.sv
`default_nettype none

module exec_top_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_OPS        = 300;
   localparam int TIMEOUT_CYCLES = 40 * NUM_OPS;

   logic                        clk;
   logic                        rst_n;
   logic                        in_valid;
   exec_pipe_pkg::issue_op_t    in_op;
   logic                        in_ready;
   logic                        out_valid;
   exec_pipe_pkg::exec_result_t out_res;
   logic                        out_ready;

   logic [31:0]                 lcg_state;
   mips_isa_pkg::data_t         model_hi;
   mips_isa_pkg::data_t         model_lo;
   exec_pipe_pkg::exec_result_t exp_q[$];
   int                          issued;
   int                          taken;
   int                          cycles;
   int                          stall_left;
   logic                        accepted;
   logic                        saw_full;

   exec_top dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_op     (in_op),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_res   (out_res),
      .out_ready (out_ready)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
      $display("** Error: %s = %h, expected %h", name, got, want);
      abort_run("result differs from the reference model");
   endtask

   // ------------------------------
   // Stimulus
   // ------------------------------
   function automatic exec_pipe_pkg::issue_op_t make_op(int idx);
      exec_pipe_pkg::issue_op_t op;
      logic [31:0]              rnd;
      logic [3:0]               pick;
      rnd            = next_rand();
      pick           = rnd[11:8];
      op.oper        = rnd[0] ? mips_isa_pkg::OPER_ALUS : mips_isa_pkg::OPER_ALUU;
      op.func        = mips_isa_pkg::FUNC_PASS;
      op.source_a    = next_rand();
      op.source_b    = next_rand();
      op.cp0_rt_data = next_rand();
      op.tag         = 4'(idx);
      if (idx < 32) begin
         // Every shift amount once while the shift kind rotates.
         op.source_b[4:0] = 5'(idx);
         case (idx % 3)
            0:       op.func = mips_isa_pkg::FUNC_SLL;
            1:       op.func = mips_isa_pkg::FUNC_SRL;
            default: op.func = mips_isa_pkg::FUNC_SRA;
         endcase
      end else if (idx < 34) begin
         op.func     = mips_isa_pkg::FUNC_DIV;
         op.source_b = '0;
      end else if (pick < 4'd10) begin
         op.func = 5'(rnd[16:12] % 5'd14);
      end else if (pick == 4'd15) begin
         op.func     = rnd[12] ? mips_isa_pkg::FUNC_DIV : mips_isa_pkg::FUNC_MUL;
         op.source_b = {24'h0, rnd[23:16]};
         if (rnd[24]) op.source_b = -op.source_b;
         if (rnd[14:13] == 2'b00) op.source_b = '0;
      end else begin
         case (pick)
            4'd10:   op.oper = mips_isa_pkg::OPER_MTHI;
            4'd11:   op.oper = mips_isa_pkg::OPER_MTLO;
            4'd12:   op.oper = mips_isa_pkg::OPER_MFHI;
            4'd13:   op.oper = mips_isa_pkg::OPER_MFLO;
            default: op.oper = mips_isa_pkg::OPER_MFC0;
         endcase
      end
      return op;
   endfunction

   // ------------------------------
   // Reference model
   // ------------------------------
   // Ops retire in order, so HI/LO are updated here at issue time.
   function automatic exec_pipe_pkg::exec_result_t expect_result(exec_pipe_pkg::issue_op_t op);
      exec_pipe_pkg::exec_result_t res;
      mips_isa_pkg::data_t         a;
      mips_isa_pkg::data_t         b;
      mips_isa_pkg::data_t         sum;
      mips_isa_pkg::data_t         diff;
      logic [63:0]                 prod;
      longint                      sa;
      longint                      sb;
      longint                      q;
      longint                      rm;
      logic                        is_s;
      a               = op.source_a;
      b               = op.source_b;
      sum             = a + b;
      diff            = a - b;
      is_s            = (op.oper == mips_isa_pkg::OPER_ALUS);
      sa              = longint'($signed(a));
      sb              = longint'($signed(b));
      res.tag         = op.tag;
      res.result      = '0;
      res.ov          = 1'b0;
      res.cp0_rd_data = a;
      case (op.oper)
         mips_isa_pkg::OPER_MFHI: res.result = model_hi;
         mips_isa_pkg::OPER_MFLO: res.result = model_lo;
         mips_isa_pkg::OPER_MFC0: res.result = op.cp0_rt_data;
         mips_isa_pkg::OPER_MTHI: begin
            model_hi   = a;
            res.result = a;
         end
         mips_isa_pkg::OPER_MTLO: begin
            model_lo   = a;
            res.result = a;
         end
         default: begin
            case (op.func)
               mips_isa_pkg::FUNC_AND:  res.result = a & b;
               mips_isa_pkg::FUNC_OR:   res.result = a | b;
               mips_isa_pkg::FUNC_XOR:  res.result = a ^ b;
               mips_isa_pkg::FUNC_NOR:  res.result = ~(a | b);
               mips_isa_pkg::FUNC_LUI:  res.result = {b[15:0], 16'h0000};
               mips_isa_pkg::FUNC_SLL:  res.result = a << b[4:0];
               mips_isa_pkg::FUNC_SRL:  res.result = a >> b[4:0];
               mips_isa_pkg::FUNC_SRA:
                  res.result = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
               mips_isa_pkg::FUNC_ADD: begin
                  res.result = sum;
                  res.ov     = is_s && (a[31] == b[31]) && (sum[31] != a[31]);
               end
               mips_isa_pkg::FUNC_SUB: begin
                  res.result = diff;
                  res.ov     = is_s && (a[31] != b[31]) && (diff[31] != a[31]);
               end
               mips_isa_pkg::FUNC_SLT: begin
                  // Flipping the sign bits turns a signed compare into an unsigned one.
                  if (is_s) res.result = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
                  else      res.result = {31'b0, a < b};
               end
               mips_isa_pkg::FUNC_MUL: begin
                  if (is_s) prod = sa * sb;
                  else      prod = {32'h0, a} * {32'h0, b};
                  model_hi        = prod[63:32];
                  model_lo        = prod[31:0];
                  res.result      = model_lo;
                  res.cp0_rd_data = '0;
               end
               mips_isa_pkg::FUNC_DIV: begin
                  if (b == '0) begin
                     model_hi = a;
                     model_lo = 32'hffff_ffff;
                  end else if (is_s) begin
                     q        = sa / sb;
                     rm       = sa % sb;
                     model_hi = rm[31:0];
                     model_lo = q[31:0];
                  end else begin
                     model_hi = a % b;
                     model_lo = a / b;
                  end
                  res.result      = model_lo;
                  res.cp0_rd_data = '0;
               end
               mips_isa_pkg::FUNC_PASS: res.result = a;
               default:                 res.result = '0;
            endcase
         end
      endcase
      return res;
   endfunction

   task automatic check_result();
      exec_pipe_pkg::exec_result_t exp;
      if (exp_q.size() == 0) begin
         abort_run("a result came out with no op outstanding");
      end else begin
         exp = exp_q.pop_front();
         assert (out_res.tag == exp.tag)
            else report_mismatch("out_res.tag", 32'(out_res.tag), 32'(exp.tag));
         assert (out_res.result == exp.result)
            else report_mismatch("out_res.result", out_res.result, exp.result);
         assert (out_res.ov == exp.ov)
            else report_mismatch("out_res.ov", 32'(out_res.ov), 32'(exp.ov));
         assert (out_res.cp0_rd_data == exp.cp0_rd_data)
            else report_mismatch("out_res.cp0_rd_data", out_res.cp0_rd_data, exp.cp0_rd_data);
         taken++;
      end
   endtask

   // ------------------------------
   // Per-cycle drivers
   // ------------------------------
   task automatic drive_result_side();
      logic [31:0] rnd;
      rnd = next_rand();
      if (stall_left != 0) begin
         out_ready = 1'b0;
         stall_left--;
      end else if (rnd[7:4] == 4'd0) begin
         // A long stall fills the queue and uses up the credits.
         out_ready  = 1'b0;
         stall_left = 12;
      end else begin
         out_ready = (rnd[1:0] != 2'b00);
      end
      // out_valid and out_res only move on the rising edge.
      if (out_valid && out_ready) check_result();
   endtask

   task automatic drive_issue_side();
      logic [31:0] rnd;
      rnd = next_rand();
      if (!in_ready) saw_full = 1'b1;
      if (!in_valid || accepted) begin
         accepted = 1'b0;
         if (issued < NUM_OPS && rnd[2:0] != 3'd0) begin
            in_valid = 1'b1;
            in_op    = make_op(issued);
         end else begin
            in_valid = 1'b0;
         end
      end
      // in_ready holds until the next rising edge, so this handshake will happen.
      if (in_valid && in_ready) begin
         exp_q.push_back(expect_result(in_op));
         accepted = 1'b1;
         issued++;
      end
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      in_op      = '0;
      out_ready  = 1'b0;
      lcg_state  = 32'hff7e_551c;
      model_hi   = '0;
      model_lo   = '0;
      issued     = 0;
      taken      = 0;
      cycles     = 0;
      stall_left = 0;
      accepted   = 1'b0;
      saw_full   = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      assert (in_ready === 1'b1) else abort_run("in_ready is low after reset");
      assert (out_valid === 1'b0) else abort_run("out_valid is high after reset");
      while (taken < NUM_OPS && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
         if (dut0.chk0.failures != 0) abort_run("a protocol assertion failed");
         drive_result_side();
         drive_issue_side();
      end
      // One more edge so the last result is taken and the assertions see it.
      @(negedge clk);
      if (taken == NUM_OPS && dut0.chk0.failures == 0 && saw_full) begin
         $display("Test passed");
         $finish;
      end else if (taken < NUM_OPS) begin
         abort_run($sformatf("timeout after %0d cycles with %0d of %0d results",
                             cycles, taken, NUM_OPS));
      end else if (dut0.chk0.failures != 0) begin
         abort_run("a protocol assertion failed");
      end else begin
         abort_run("in_ready never fell while the output was stalled");
      end
   end

endmodule

`default_nettype wire

//--- testbench/exec_top_asserts.sv
`default_nettype none

module exec_top_asserts (
   input logic                        clk,
   input logic                        rst_n,
   input logic                        in_valid,
   input logic                        in_ready,
   input logic                        push,
   input logic                        pop,
   input logic                        out_valid,
   input logic                        out_ready,
   input exec_pipe_pkg::exec_result_t out_res,
   input exec_pipe_pkg::credit_t      credits
);
   timeunit 1ns;
   timeprecision 100ps;

   int                     failures = 0;
   // Ops between input handshake and pop, and ops written into the queue.
   exec_pipe_pkg::credit_t held;
   exec_pipe_pkg::credit_t queued;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         held   <= '0;
         queued <= '0;
      end else begin
         held   <= held + 3'(in_valid && in_ready) - 3'(pop);
         queued <= queued + 3'(push) - 3'(pop);
      end
   end

   // ------------------------------
   // Credit flow
   // ------------------------------
   credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
      credits <= exec_pipe_pkg::credit_t'(exec_pipe_pkg::QUEUE_DEPTH))
      else begin
         $error("credit count %0d above the queue depth", credits);
         failures++;
      end

   ready_tracks_credits: assert property (@(posedge clk) disable iff (!rst_n)
      in_ready == (held != exec_pipe_pkg::credit_t'(exec_pipe_pkg::QUEUE_DEPTH)))
      else begin
         $error("in_ready %0b with %0d ops held", in_ready, held);
         failures++;
      end

   // ------------------------------
   // Queue and result port
   // ------------------------------
   pop_needs_head: assert property (@(posedge clk) disable iff (!rst_n)
      pop |-> (queued != '0))
      else begin
         $error("pop while the queue is empty");
         failures++;
      end

   result_held: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_res)))
      else begin
         $error("result changed or dropped during a stall");
         failures++;
      end

endmodule

bind exec_top exec_top_asserts chk0 (
   .clk       (clk),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .push      (push),
   .pop       (pop),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_res   (out_res),
   .credits   (issue0.credits)
);

`default_nettype wire

//--- verilog/exec_top.sv
`default_nettype none

module exec_top (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        in_valid,
   input  exec_pipe_pkg::issue_op_t    in_op,
   output logic                        in_ready,
   output logic                        out_valid,
   output exec_pipe_pkg::exec_result_t out_res,
   input  logic                        out_ready
);

   logic                     push;
   exec_pipe_pkg::issue_op_t push_op;
   logic                     credit_return;
   logic                     head_valid;
   exec_pipe_pkg::issue_op_t head_op;
   logic                     pop;

   op_issue issue0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (in_valid),
      .in_op         (in_op),
      .in_ready      (in_ready),
      .push          (push),
      .push_op       (push_op),
      .credit_return (credit_return)
   );

   op_queue queue0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .push          (push),
      .push_op       (push_op),
      .pop           (pop),
      .head_valid    (head_valid),
      .head_op       (head_op),
      .credit_return (credit_return)
   );

   exec_unit exec0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .head_valid (head_valid),
      .head_op    (head_op),
      .pop        (pop),
      .out_valid  (out_valid),
      .out_res    (out_res),
      .out_ready  (out_ready)
   );

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`default_nettype none

module exec_unit (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        head_valid,
   input  exec_pipe_pkg::issue_op_t    head_op,
   output logic                        pop,
   output logic                        out_valid,
   output exec_pipe_pkg::exec_result_t out_res,
   input  logic                        out_ready
);

   mips_isa_pkg::data_t hi_q;
   mips_isa_pkg::data_t lo_q;
   mips_isa_pkg::data_t alu_result;
   mips_isa_pkg::data_t alu_cp0_rd;
   mips_isa_pkg::data_t hi_wdata;
   mips_isa_pkg::data_t lo_wdata;
   logic                hi_write;
   logic                lo_write;
   logic                alu_ov;
   logic                md_start;
   logic                md_sign;
   logic                md_busy;
   logic                md_go;
   logic                md_done;
   mips_isa_pkg::data_t md_hi;
   mips_isa_pkg::data_t md_lo;
   exec_pipe_pkg::tag_t md_tag;
   logic                slot_free;
   logic                sgl_go;

   assign slot_free = !out_valid || out_ready;
   assign pop       = head_valid && !md_busy && slot_free;
   assign md_go     = pop && md_start;
   assign sgl_go    = pop && !md_start;

   sgl_alu alu0 (
      .oper          (head_op.oper),
      .func          (head_op.func),
      .source_a      (head_op.source_a),
      .source_b      (head_op.source_b),
      .cp0_rt_data   (head_op.cp0_rt_data),
      .hi            (hi_q),
      .lo            (lo_q),
      .result        (alu_result),
      .cp0_rd_data   (alu_cp0_rd),
      .hi_write      (hi_write),
      .lo_write      (lo_write),
      .ov            (alu_ov),
      .md_start      (md_start),
      .md_sign       (md_sign),
      .hi_write_data (hi_wdata),
      .lo_write_data (lo_wdata)
   );

   mul_div_iter md0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .start  (md_go),
      .sign   (md_sign),
      .is_div (head_op.func == mips_isa_pkg::FUNC_DIV),
      .a      (head_op.source_a),
      .b      (head_op.source_b),
      .done   (md_done),
      .hi_out (md_hi),
      .lo_out (md_lo)
   );

   // ------------------------------
   // Control and HI/LO
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         md_busy   <= 1'b0;
         out_valid <= 1'b0;
         hi_q      <= '0;
         lo_q      <= '0;
      end else begin
         if (md_go) begin
            md_busy <= 1'b1;
         end else if (md_done) begin
            md_busy <= 1'b0;
         end
         if (sgl_go || md_done) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
         if (md_done) begin
            hi_q <= md_hi;
            lo_q <= md_lo;
         end else if (sgl_go) begin
            if (hi_write) hi_q <= hi_wdata;
            if (lo_write) lo_q <= lo_wdata;
         end
      end
   end

   // Result slot, the value stays put until it is taken.
   always_ff @(posedge clk) begin
      if (md_go) begin
         md_tag <= head_op.tag;
      end
      if (md_done) begin
         out_res <= '{tag: md_tag, result: md_lo, ov: 1'b0, cp0_rd_data: '0};
      end else if (sgl_go) begin
         out_res <= '{tag: head_op.tag, result: alu_result, ov: alu_ov,
                      cp0_rd_data: alu_cp0_rd};
      end
   end

endmodule

`default_nettype wire

//--- verilog/op_queue.sv
`default_nettype none

module op_queue (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     push,
   input  exec_pipe_pkg::issue_op_t push_op,
   input  logic                     pop,
   output logic                     head_valid,
   output exec_pipe_pkg::issue_op_t head_op,
   output logic                     credit_return
);

   exec_pipe_pkg::issue_op_t mem [exec_pipe_pkg::QUEUE_DEPTH];
   exec_pipe_pkg::q_ptr_t    wr_ptr;
   exec_pipe_pkg::q_ptr_t    rd_ptr;
   exec_pipe_pkg::credit_t   count;
   logic                     do_pop;

   assign head_valid    = (count != '0);
   assign head_op       = mem[rd_ptr];
   assign do_pop        = pop && head_valid;
   // Each slot freed goes straight back to the issue side.
   assign credit_return = do_pop;

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, do_pop})
            2'b10:   count <= count + 3'd1;
            2'b01:   count <= count - 3'd1;
            default: count <= count;
         endcase
      end
   end

   // Storage, no full check since the issue side holds the credits.
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_op;
      end
   end

endmodule

`default_nettype wire

//--- verilog/op_issue.sv
`default_nettype none

module op_issue (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_valid,
   input  exec_pipe_pkg::issue_op_t in_op,
   output logic                     in_ready,
   output logic                     push,
   output exec_pipe_pkg::issue_op_t push_op,
   input  logic                     credit_return
);

   exec_pipe_pkg::credit_t credits;
   logic                   take;

   // One credit per free queue slot.
   assign in_ready = (credits != '0);
   assign take     = in_valid && in_ready;

   // The credit is spent at the handshake so a second op cannot slip in
   // before the push reaches the queue.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits <= exec_pipe_pkg::credit_t'(exec_pipe_pkg::QUEUE_DEPTH);
      end else begin
         case ({take, credit_return})
            2'b10:   credits <= credits - 3'd1;
            2'b01:   credits <= credits + 3'd1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         push <= 1'b0;
      end else begin
         push <= take;
      end
   end

   // Payload register.
   always_ff @(posedge clk) begin
      if (take) begin
         push_op <= in_op;
      end
   end

endmodule

`default_nettype wire

//--- verilog/mul_div_iter.sv
`default_nettype none

module mul_div_iter (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                start,
   input  logic                sign,
   input  logic                is_div,
   input  mips_isa_pkg::data_t a,
   input  mips_isa_pkg::data_t b,
   output logic                done,
   output mips_isa_pkg::data_t hi_out,
   output mips_isa_pkg::data_t lo_out
);

   exec_pipe_pkg::md_state_t state;
   logic [4:0]               step;
   logic                     div_q;
   logic                     neg_q;
   logic                     neg_r;
   mips_isa_pkg::data_t      hi_r;
   mips_isa_pkg::data_t      lo_r;
   mips_isa_pkg::data_t      b_r;
   mips_isa_pkg::data_t      a_mag;
   mips_isa_pkg::data_t      b_mag;
   logic [32:0]              add_sum;
   logic [32:0]              shifted;
   logic [33:0]              trial;
   logic [63:0]              prod_neg;
   logic                     load;

   assign a_mag   = (sign && a[31]) ? -a : a;
   assign b_mag   = (sign && b[31]) ? -b : b;
   assign load    = (state == exec_pipe_pkg::MD_IDLE) && start;
   assign add_sum = {1'b0, hi_r} + (lo_r[0] ? {1'b0, b_r} : 33'd0);
   assign shifted = {hi_r, lo_r[31]};
   assign trial   = {1'b0, shifted} - {2'b00, b_r};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= exec_pipe_pkg::MD_IDLE;
         step  <= '0;
      end else begin
         case (state)
            exec_pipe_pkg::MD_IDLE: if (start) state <= exec_pipe_pkg::MD_RUN;
            exec_pipe_pkg::MD_RUN:  if (step == 5'd31) state <= exec_pipe_pkg::MD_DONE;
            default:                state <= exec_pipe_pkg::MD_IDLE;
         endcase
         step <= (state == exec_pipe_pkg::MD_RUN) ? step + 5'd1 : 5'd0;
      end
   end

   // ------------------------------
   // Datapath
   // ------------------------------
   // Works on magnitudes, signs are put back at the output.
   always_ff @(posedge clk) begin
      if (load) begin
         div_q <= is_div;
         neg_q <= sign && (a[31] ^ b[31]) && (!is_div || (b != '0));
         neg_r <= sign && a[31];
         b_r   <= b_mag;
         hi_r  <= '0;
         lo_r  <= a_mag;
      end else if (state == exec_pipe_pkg::MD_RUN) begin
         if (!div_q) begin
            hi_r <= add_sum[32:1];
            lo_r <= {add_sum[0], lo_r[31:1]};
         end else if (!trial[33]) begin
            hi_r <= trial[31:0];
            lo_r <= {lo_r[30:0], 1'b1};
         end else begin
            hi_r <= shifted[31:0];
            lo_r <= {lo_r[30:0], 1'b0};
         end
      end
   end

   assign prod_neg = -{hi_r, lo_r};
   assign done     = (state == exec_pipe_pkg::MD_DONE);

   always_comb begin
      if (div_q) begin
         hi_out = neg_r ? -hi_r : hi_r;
         lo_out = neg_q ? -lo_r : lo_r;
      end else begin
         {hi_out, lo_out} = neg_q ? prod_neg : {hi_r, lo_r};
      end
   end

endmodule

`default_nettype wire

//--- verilog/sgl_alu.sv
`default_nettype none

module sgl_alu (
   input  mips_isa_pkg::oper_t oper,
   input  mips_isa_pkg::func_t func,
   input  mips_isa_pkg::data_t source_a,
   input  mips_isa_pkg::data_t source_b,
   input  mips_isa_pkg::data_t cp0_rt_data,
   input  mips_isa_pkg::data_t hi,
   input  mips_isa_pkg::data_t lo,
   output mips_isa_pkg::data_t result,
   output mips_isa_pkg::data_t cp0_rd_data,
   output logic                hi_write,
   output logic                lo_write,
   output logic                ov,
   output logic                md_start,
   output logic                md_sign,
   output mips_isa_pkg::data_t hi_write_data,
   output mips_isa_pkg::data_t lo_write_data
);

   mips_isa_pkg::data_t add_result;
   mips_isa_pkg::data_t sub_result;
   mips_isa_pkg::data_t alu_result;
   logic [4:0]          shamt;
   logic                is_alu;
   logic                is_signed;
   logic                slt_lt;

   assign add_result = source_a + source_b;
   assign sub_result = source_a - source_b;
   assign shamt      = source_b[4:0];
   assign is_signed  = (oper == mips_isa_pkg::OPER_ALUS);
   assign is_alu     = is_signed || (oper == mips_isa_pkg::OPER_ALUU);
   assign slt_lt     = is_signed ? ($signed(source_a) < $signed(source_b))
                                 : (source_a < source_b);

   // ------------------------------
   // Function decode
   // ------------------------------
   always_comb begin
      case (func)
         mips_isa_pkg::FUNC_AND:  alu_result = source_a & source_b;
         mips_isa_pkg::FUNC_OR:   alu_result = source_a | source_b;
         mips_isa_pkg::FUNC_XOR:  alu_result = source_a ^ source_b;
         mips_isa_pkg::FUNC_NOR:  alu_result = ~(source_a | source_b);
         mips_isa_pkg::FUNC_LUI:  alu_result = {source_b[15:0], 16'h0000};
         mips_isa_pkg::FUNC_SLL:  alu_result = source_a << shamt;
         mips_isa_pkg::FUNC_SRL:  alu_result = source_a >> shamt;
         mips_isa_pkg::FUNC_SRA:  alu_result = $signed(source_a) >>> shamt;
         mips_isa_pkg::FUNC_ADD:  alu_result = add_result;
         mips_isa_pkg::FUNC_SUB:  alu_result = sub_result;
         mips_isa_pkg::FUNC_SLT:  alu_result = {31'b0, slt_lt};
         mips_isa_pkg::FUNC_PASS: alu_result = source_a;
         default:                 alu_result = '0;
      endcase
   end

   // Moves from HI/LO and CP0 ignore func.
   always_comb begin
      case (oper)
         mips_isa_pkg::OPER_MFHI: result = hi;
         mips_isa_pkg::OPER_MFLO: result = lo;
         mips_isa_pkg::OPER_MFC0: result = cp0_rt_data;
         default:                 result = alu_result;
      endcase
   end

   assign ov = is_signed &&
               (((func == mips_isa_pkg::FUNC_ADD) && (source_a[31] == source_b[31]) &&
                 (add_result[31] != source_a[31])) ||
                ((func == mips_isa_pkg::FUNC_SUB) && (source_a[31] != source_b[31]) &&
                 (sub_result[31] != source_a[31])));

   // ------------------------------
   // Side outputs
   // ------------------------------
   assign cp0_rd_data   = source_a;
   assign hi_write      = (oper == mips_isa_pkg::OPER_MTHI);
   assign lo_write      = (oper == mips_isa_pkg::OPER_MTLO);
   assign hi_write_data = source_a;
   assign lo_write_data = source_a;
   assign md_start      = is_alu && ((func == mips_isa_pkg::FUNC_MUL) ||
                                     (func == mips_isa_pkg::FUNC_DIV));
   assign md_sign       = is_signed;

endmodule

`default_nettype wire

//--- verilog/exec_pipe_pkg.sv
`default_nettype none

package exec_pipe_pkg;

   localparam int QUEUE_DEPTH = 4;
   localparam int Q_PTR_W     = $clog2(QUEUE_DEPTH);

   typedef logic [2:0]         credit_t;
   typedef logic [3:0]         tag_t;
   typedef logic [Q_PTR_W-1:0] q_ptr_t;

   // ------------------------------
   // Pipeline payloads
   // ------------------------------
   typedef struct packed {
      mips_isa_pkg::oper_t oper;
      mips_isa_pkg::func_t func;
      mips_isa_pkg::data_t source_a;
      mips_isa_pkg::data_t source_b;
      mips_isa_pkg::data_t cp0_rt_data;
      tag_t                tag;
   } issue_op_t;

   typedef struct packed {
      tag_t                tag;
      mips_isa_pkg::data_t result;
      logic                ov;
      mips_isa_pkg::data_t cp0_rd_data;
   } exec_result_t;

   // Multiply/divide sequencer.
   typedef enum logic [1:0] {
      MD_IDLE,
      MD_RUN,
      MD_DONE
   } md_state_t;

endpackage

`default_nettype wire

//--- verilog/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int DATA_W = 32;
   localparam int OPER_W = 4;
   localparam int FUNC_W = 5;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [OPER_W-1:0] oper_t;
   typedef logic [FUNC_W-1:0] func_t;

   // ------------------------------
   // Operation classes
   // ------------------------------
   // Signed and unsigned ALU ops share the same func codes.
   localparam oper_t OPER_ALUS = 4'd0;
   localparam oper_t OPER_ALUU = 4'd1;
   localparam oper_t OPER_MFHI = 4'd2;
   localparam oper_t OPER_MFLO = 4'd3;
   localparam oper_t OPER_MTHI = 4'd4;
   localparam oper_t OPER_MTLO = 4'd5;
   localparam oper_t OPER_MFC0 = 4'd6;

   // ------------------------------
   // Function codes
   // ------------------------------
   localparam func_t FUNC_AND  = 5'd0;
   localparam func_t FUNC_OR   = 5'd1;
   localparam func_t FUNC_XOR  = 5'd2;
   localparam func_t FUNC_NOR  = 5'd3;
   localparam func_t FUNC_LUI  = 5'd4;
   localparam func_t FUNC_SLL  = 5'd5;
   localparam func_t FUNC_SRL  = 5'd6;
   localparam func_t FUNC_SRA  = 5'd7;
   localparam func_t FUNC_ADD  = 5'd8;
   localparam func_t FUNC_SUB  = 5'd9;
   localparam func_t FUNC_SLT  = 5'd10;
   localparam func_t FUNC_MUL  = 5'd11;
   localparam func_t FUNC_DIV  = 5'd12;
   // Moves source_a straight through, as for a CP0 write.
   localparam func_t FUNC_PASS = 5'd13;

endpackage

`default_nettype wire
